// File: compile.f
+incdir+hdl
hdl/cmac_axis_pkg.sv
hdl/cmac_reg_pkg.sv
hdl/cmac_loopback.sv
hdl/axis_stats.sv
hdl/cmac_regs.sv
hdl/alveo_cmac_port.sv
tests/cmac_port_assert.sv
tests/cmac_port_tb.sv

// File: hdl/alveo_cmac_port.sv
`include "cmac_config.svh"

module alveo_cmac_port
    import cmac_axis_pkg::*;
    import cmac_reg_pkg::*;
#(
    parameter int PORT_ID = `CMAC_PORT_ID_DEFAULT
) (
    input  logic        clk,
    input  logic        arst_n,
    // Outgoing packets from the core
    input  axis_beat_t  tx_beat,
    output axis_ready_t tx_ready,
    // Incoming packets to the core
    output axis_beat_t  rx_beat,
    input  axis_ready_t rx_ready,
    // Control and statistics
    input  reg_req_t    reg_req,
    output reg_rsp_t    reg_rsp
);

    logic   loopback_en;
    logic   clear;
    stats_t tx_stats;
    stats_t rx_stats;

    // =================================================================
    // MAC stand-in
    // =================================================================
    cmac_loopback #(
        .PORT_ID (PORT_ID)
    ) loopback_i (
        .clk,
        .arst_n,
        .tx_beat,
        .tx_ready,
        .rx_beat,
        .rx_ready,
        .loopback_en
    );

    // =================================================================
    // Stream monitors
    // =================================================================
    // Transmit side, counts every accepted beat incl. dropped ones
    axis_stats tx_stats_i (
        .clk,
        .arst_n,
        .beat   (tx_beat),
        .ready  (tx_ready.ready),
        .clear,
        .stats  (tx_stats)
    );

    axis_stats rx_stats_i (
        .clk,
        .arst_n,
        .beat   (rx_beat),
        .ready  (rx_ready.ready),
        .clear,
        .stats  (rx_stats)
    );

    // =================================================================
    // Register block
    // =================================================================
    cmac_regs #(
        .PORT_ID (PORT_ID)
    ) regs_i (
        .clk,
        .arst_n,
        .reg_req,
        .reg_rsp,
        .tx_stats,
        .rx_stats,
        .loopback_en,
        .clear
    );

endmodule : alveo_cmac_port

// File: hdl/axis_stats.sv
`include "cmac_config.svh"

module axis_stats
    import cmac_axis_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    // Stream being watched
    input  axis_beat_t beat,
    input  logic       ready,
    // Zero both counters
    input  logic       clear,
    output stats_t     stats
);

    localparam int NB_WIDTH = $clog2(`CMAC_DATA_BYTES + 1);

    logic                accept;
    logic [NB_WIDTH-1:0] nbytes;

    // =================================================================
    // Byte count of one beat
    // =================================================================
    function automatic logic [NB_WIDTH-1:0] keep_bytes(
        input logic [`CMAC_DATA_BYTES-1:0] keep
    );
        logic [NB_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < `CMAC_DATA_BYTES; i++) begin
            n = n + NB_WIDTH'(keep[i]);
        end
        return n;
    endfunction

    assign accept = beat.valid && ready;
    assign nbytes = keep_bytes(beat.keep);

    // =================================================================
    // Counters
    // =================================================================
    // Clear wins over a beat on the same edge
    // Both counters wrap silently
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stats <= '0;
        end else if (clear) begin
            stats <= '0;
        end else if (accept) begin
            stats.bytes <= stats.bytes + `CMAC_CNT_WIDTH'(nbytes);
            // Packet ends on its last beat
            if (beat.last) begin
                stats.pkts <= stats.pkts + 1'b1;
            end
        end
    end

endmodule : axis_stats

// File: hdl/cmac_axis_pkg.sv
`include "cmac_config.svh"

package cmac_axis_pkg;

    // =================================================================
    // Stream beat
    // =================================================================
    // Forward half of the packet stream, one struct per beat
    typedef struct packed {
        logic                          valid;
        logic [`CMAC_DATA_WIDTH-1:0]   data;
        // One bit per valid byte, low bytes first
        logic [`CMAC_DATA_BYTES-1:0]   keep;
        logic                          last;
        logic [7:0]                    id;
    } axis_beat_t;

    // Return half of the handshake
    typedef struct packed {
        logic ready;
    } axis_ready_t;

    // =================================================================
    // Monitor output
    // =================================================================
    typedef struct packed {
        logic [`CMAC_CNT_WIDTH-1:0] pkts;
        logic [`CMAC_CNT_WIDTH-1:0] bytes;
    } stats_t;

endpackage : cmac_axis_pkg

// File: hdl/cmac_config.svh
`ifndef CMAC_CONFIG_SVH
`define CMAC_CONFIG_SVH

// =====================================================================
// Stream geometry
// =====================================================================
// Bytes per stream beat
`define CMAC_DATA_BYTES 8
// Data bus width in bits
`define CMAC_DATA_WIDTH (`CMAC_DATA_BYTES * 8)

// =====================================================================
// Statistics and identity
// =====================================================================
// Width of each packet or byte counter
`define CMAC_CNT_WIDTH 32
// Port number stamped into the id field and the identity register
`define CMAC_PORT_ID_DEFAULT 0

`endif

// File: hdl/cmac_loopback.sv
`include "cmac_config.svh"

module cmac_loopback
    import cmac_axis_pkg::*;
#(
    parameter int PORT_ID = `CMAC_PORT_ID_DEFAULT
) (
    input  logic        clk,
    input  logic        arst_n,
    // Transmit side, from the core
    input  axis_beat_t  tx_beat,
    output axis_ready_t tx_ready,
    // Receive side, to the core
    output axis_beat_t  rx_beat,
    input  axis_ready_t rx_ready,
    input  logic        loopback_en
);

    // =================================================================
    // Output stage
    // =================================================================
    logic                          out_valid;
    logic [`CMAC_DATA_WIDTH-1:0]   out_data;
    logic [`CMAC_DATA_BYTES-1:0]   out_keep;
    logic                          out_last;
    logic                          tx_take;
    logic                          load;

    // Drop mode never stalls the core
    // Loopback mode accepts when the stage is empty or draining
    assign tx_ready.ready = !loopback_en || !out_valid || rx_ready.ready;

    assign tx_take = tx_beat.valid && tx_ready.ready;
    // Only looped beats enter the stage, dropped ones vanish here
    assign load    = tx_take && loopback_en;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (rx_ready.ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload follows the valid bit
    always_ff @(posedge clk) begin
        if (load) begin
            out_data <= tx_beat.data;
            out_keep <= tx_beat.keep;
            out_last <= tx_beat.last;
        end
    end

    // Receive beat, id stamped with this port
    assign rx_beat.valid = out_valid;
    assign rx_beat.data  = out_data;
    assign rx_beat.keep  = out_keep;
    assign rx_beat.last  = out_last;
    assign rx_beat.id    = 8'(PORT_ID);

endmodule : cmac_loopback

// File: hdl/cmac_reg_pkg.sv
package cmac_reg_pkg;

    // =================================================================
    // Register bus channels
    // =================================================================
    // Host to port, write address and data share one handshake
    typedef struct packed {
        logic        wvalid;
        logic [7:0]  waddr;
        logic [31:0] wdata;
        logic        rvalid;
        logic [7:0]  raddr;
        // Response side acceptance
        logic        bready;
        logic        rready;
    } reg_req_t;

    // Port to host
    typedef struct packed {
        logic        wready;
        // Read address ready
        logic        rready_a;
        logic        bvalid;
        logic [1:0]  bresp;
        // Read data valid
        logic        dvalid;
        logic [31:0] rdata;
        logic [1:0]  dresp;
    } reg_rsp_t;

    // =================================================================
    // Register map
    // =================================================================
    localparam logic [7:0] REG_ID       = 8'h00;
    localparam logic [7:0] REG_CTRL     = 8'h04;
    localparam logic [7:0] REG_TX_PKTS  = 8'h08;
    localparam logic [7:0] REG_TX_BYTES = 8'h0C;
    localparam logic [7:0] REG_RX_PKTS  = 8'h10;
    localparam logic [7:0] REG_RX_BYTES = 8'h14;

    // Response codes
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_DECERR = 2'd3;

    // Upper part of the identity word, port number goes below it
    localparam logic [23:0] ID_MAGIC = 24'hCAC000;

endpackage : cmac_reg_pkg

// File: hdl/cmac_regs.sv
`include "cmac_config.svh"

module cmac_regs
    import cmac_axis_pkg::*;
    import cmac_reg_pkg::*;
#(
    parameter int PORT_ID = `CMAC_PORT_ID_DEFAULT
) (
    input  logic     clk,
    input  logic     arst_n,
    // Host register bus
    input  reg_req_t reg_req,
    output reg_rsp_t reg_rsp,
    // Counter inputs from both monitors
    input  stats_t   tx_stats,
    input  stats_t   rx_stats,
    // Control outputs
    output logic     loopback_en,
    output logic     clear
);

    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        dvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  dresp_q;
    logic        wr_take;
    logic        rd_take;
    logic [31:0] rd_mux;

    // Offsets that exist in the map
    function automatic logic known(input logic [7:0] addr);
        return addr inside {REG_ID, REG_CTRL, REG_TX_PKTS, REG_TX_BYTES,
                            REG_RX_PKTS, REG_RX_BYTES};
    endfunction

    // =================================================================
    // Write channel
    // =================================================================
    // One write in flight, next one waits for the response
    assign wr_take = reg_req.wvalid && !bvalid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid_q    <= 1'b0;
            loopback_en <= 1'b0;
            clear       <= 1'b0;
        end else begin
            // Clear is a single cycle pulse
            clear <= 1'b0;
            if (wr_take) begin
                bvalid_q <= 1'b1;
                if (reg_req.waddr == REG_CTRL) begin
                    loopback_en <= reg_req.wdata[0];
                    clear       <= reg_req.wdata[1];
                end
            end else if (reg_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // Writes to read-only offsets are ignored but answer OKAY
    always_ff @(posedge clk) begin
        if (wr_take) begin
            bresp_q <= known(reg_req.waddr) ? RESP_OKAY : RESP_DECERR;
        end
    end

    // =================================================================
    // Read channel
    // =================================================================
    assign rd_take = reg_req.rvalid && !dvalid_q;

    // Counters sampled as they stand before the accepting edge
    always_comb begin
        case (reg_req.raddr)
            REG_ID:       rd_mux = {ID_MAGIC, 8'(PORT_ID)};
            REG_CTRL:     rd_mux = {31'd0, loopback_en};
            REG_TX_PKTS:  rd_mux = 32'(tx_stats.pkts);
            REG_TX_BYTES: rd_mux = 32'(tx_stats.bytes);
            REG_RX_PKTS:  rd_mux = 32'(rx_stats.pkts);
            REG_RX_BYTES: rd_mux = 32'(rx_stats.bytes);
            default:      rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dvalid_q <= 1'b0;
        end else if (rd_take) begin
            dvalid_q <= 1'b1;
        end else if (reg_req.rready) begin
            dvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata_q <= rd_mux;
            dresp_q <= known(reg_req.raddr) ? RESP_OKAY : RESP_DECERR;
        end
    end

    // Response bundle
    assign reg_rsp.wready   = !bvalid_q;
    assign reg_rsp.rready_a = !dvalid_q;
    assign reg_rsp.bvalid   = bvalid_q;
    assign reg_rsp.bresp    = bresp_q;
    assign reg_rsp.dvalid   = dvalid_q;
    assign reg_rsp.rdata    = rdata_q;
    assign reg_rsp.dresp    = dresp_q;

endmodule : cmac_regs

// File: run.sh
#!/usr/bin/env bash
# Build and run the port testbench with Verilator
cd "$(dirname "$0")" || exit 1

# Stale logs must never count as a pass
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module cmac_port_tb -o cmac_port_sim \
    && ./obj_dir/cmac_port_sim > sim.log 2>&1 \
    || echo "Build or simulation stopped early, see sim.log"

cat sim.log 2>/dev/null

# Verdict comes from the log only
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }

// File: tests/cmac_port_assert.sv
module cmac_port_assert
    import cmac_axis_pkg::*;
    import cmac_reg_pkg::*;
(
    input logic        clk,
    input logic        arst_n,
    input axis_beat_t  tx_beat,
    input axis_ready_t tx_ready,
    input axis_beat_t  rx_beat,
    input axis_ready_t rx_ready,
    input reg_req_t    reg_req,
    input reg_rsp_t    reg_rsp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [1:0] wr_code;
    logic [1:0] rd_code;

    // Mapped offsets are word aligned and stop at the last counter
    function automatic logic mapped(input logic [7:0] addr);
        return addr[1:0] == 2'b00 && addr <= REG_RX_BYTES;
    endfunction

    assign wr_code = mapped(reg_req.waddr) ? RESP_OKAY : RESP_DECERR;
    assign rd_code = mapped(reg_req.raddr) ? RESP_OKAY : RESP_DECERR;

    // ======================================================================
    // Stream beats hold while stalled
    // ======================================================================
    tx_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tx_beat.valid && !tx_ready.ready |=> tx_beat.valid && $stable(tx_beat))
        else $error("transmit beat changed while stalled");

    rx_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rx_beat.valid && !rx_ready.ready |=> rx_beat.valid && $stable(rx_beat))
        else $error("receive beat changed while stalled");

    // ======================================================================
    // Register responses
    // ======================================================================
    // Write response held until the host takes it
    b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        reg_rsp.bvalid && !reg_req.bready |=> reg_rsp.bvalid && $stable(reg_rsp.bresp))
        else $error("write response dropped before bready");

    d_hold: assert property (@(posedge clk) disable iff (!arst_n)
        reg_rsp.dvalid && !reg_req.rready |=> reg_rsp.dvalid && $stable(reg_rsp.rdata))
        else $error("read data dropped before rready");

    // Accepted request answers next cycle with the code its offset calls for
    b_code: assert property (@(posedge clk) disable iff (!arst_n)
        reg_req.wvalid && reg_rsp.wready
        |=> reg_rsp.bvalid && reg_rsp.bresp == $past(wr_code))
        else $error("wrong write response code");

    d_code: assert property (@(posedge clk) disable iff (!arst_n)
        reg_req.rvalid && reg_rsp.rready_a
        |=> reg_rsp.dvalid && reg_rsp.dresp == $past(rd_code))
        else $error("wrong read response code");

endmodule : cmac_port_assert

// File: tests/cmac_port_tb.sv
module cmac_port_tb
    import cmac_axis_pkg::*;
    import cmac_reg_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT  = 200;
    localparam int PORT_NUM = 5;

    logic        clk;
    logic        arst_n;
    axis_beat_t  tx_beat;
    axis_ready_t tx_ready;
    axis_beat_t  rx_beat;
    axis_ready_t rx_ready;
    reg_req_t    reg_req;
    reg_rsp_t    reg_rsp;

    int          seed   = 63234;
    int          errors = 0;
    int          checks = 0;

    // Reference model, beats in flight plus the four counters
    axis_beat_t  rx_expect[$];
    logic        loop_model = 1'b0;
    logic [31:0] tx_pkts_m;
    logic [31:0] tx_bytes_m;
    logic [31:0] rx_pkts_m;
    logic [31:0] rx_bytes_m;

    alveo_cmac_port #(
        .PORT_ID (PORT_NUM)
    ) dut_i (
        .clk,
        .arst_n,
        .tx_beat,
        .tx_ready,
        .rx_beat,
        .rx_ready,
        .reg_req,
        .reg_rsp
    );

    bind alveo_cmac_port cmac_port_assert assert_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_beat  (tx_beat),
        .tx_ready (tx_ready),
        .rx_beat  (rx_beat),
        .rx_ready (rx_ready),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // Summary line, then the verdict
    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("Timeout at %0t: no %s after %0d cycles", $time, what, TIMEOUT);
        finish_run();
    endtask

    // ======================================================================
    // Register bus
    // ======================================================================
    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge clk);
        reg_req.wvalid <= 1'b1;
        reg_req.waddr  <= addr;
        reg_req.wdata  <= data;
        n = 0;
        @(negedge clk);
        while (!reg_rsp.wready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!reg_rsp.wready) give_up("write ready");
        // Accepting edge
        @(posedge clk);
        reg_req.wvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!reg_rsp.bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!reg_rsp.bvalid) give_up("write response");
        resp = reg_rsp.bresp;
        // Host takes the response after a random delay
        repeat (rand_below(3)) @(posedge clk);
        @(posedge clk);
        reg_req.bready <= 1'b1;
        @(posedge clk);
        reg_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(posedge clk);
        reg_req.rvalid <= 1'b1;
        reg_req.raddr  <= addr;
        n = 0;
        @(negedge clk);
        while (!reg_rsp.rready_a && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!reg_rsp.rready_a) give_up("read address ready");
        @(posedge clk);
        reg_req.rvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!reg_rsp.dvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!reg_rsp.dvalid) give_up("read data");
        data = reg_rsp.rdata;
        resp = reg_rsp.dresp;
        // Read data sits until the host gets to it
        repeat (rand_below(3)) @(posedge clk);
        @(posedge clk);
        reg_req.rready <= 1'b1;
        @(posedge clk);
        reg_req.rready <= 1'b0;
    endtask

    task automatic check_counters();
        logic [31:0] data;
        logic [1:0]  resp;
        read_reg(REG_TX_PKTS, data, resp);
        expect_equal("tx packet count", data, tx_pkts_m);
        read_reg(REG_TX_BYTES, data, resp);
        expect_equal("tx byte count", data, tx_bytes_m);
        read_reg(REG_RX_PKTS, data, resp);
        expect_equal("rx packet count", data, rx_pkts_m);
        read_reg(REG_RX_BYTES, data, resp);
        expect_equal("rx byte count", data, rx_bytes_m);
        expect_equal("counter read response", 32'(resp), 32'd0);
    endtask

    // ======================================================================
    // Packet stream
    // ======================================================================
    // Full keep except on last beats, random sink stalls
    task automatic send_packets(input int npkts);
        int          nbeats;
        int          n;
        logic [31:0] hi;
        logic [31:0] lo;
        for (int p = 0; p < npkts; p++) begin
            nbeats = 1 + rand_below(6);
            for (int b = 0; b < nbeats; b++) begin
                hi = $random(seed);
                lo = $random(seed);
                @(posedge clk);
                tx_beat.valid  <= 1'b1;
                tx_beat.data   <= {hi, lo};
                tx_beat.keep   <= (b == nbeats - 1) ? 8'($random(seed)) : 8'hFF;
                tx_beat.last   <= (b == nbeats - 1);
                tx_beat.id     <= 8'($random(seed));
                rx_ready.ready <= (rand_below(4) != 0);
                n = 0;
                @(negedge clk);
                while (!tx_ready.ready && n < TIMEOUT) begin
                    @(posedge clk);
                    rx_ready.ready <= (rand_below(4) != 0);
                    @(negedge clk);
                    n++;
                end
                if (!tx_ready.ready) give_up("transmit ready");
            end
            @(posedge clk);
            tx_beat.valid <= 1'b0;
            repeat (rand_below(3)) begin
                @(posedge clk);
                rx_ready.ready <= (rand_below(4) != 0);
            end
        end
    endtask

    // Sink always ready until the output stage is empty
    task automatic drain_rx();
        int n;
        @(posedge clk);
        rx_ready.ready <= 1'b1;
        n = 0;
        @(negedge clk);
        while (rx_beat.valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rx_beat.valid) give_up("empty receive stage");
        @(posedge clk);
        if (rx_expect.size() != 0) begin
            errors++;
            $display("Loopback lost %0d transmit beats", rx_expect.size());
            rx_expect.delete();
        end
    endtask

    // ======================================================================
    // Stream monitor, handshakes seen half a cycle before their edge
    // ======================================================================
    always @(negedge clk) begin : monitor
        axis_beat_t want;
        if (arst_n) begin
            if (rx_beat.valid && rx_ready.ready) begin
                if (rx_expect.size() == 0) begin
                    errors++;
                    $display("Receive beat at %0t without a transmit beat", $time);
                end else begin
                    want = rx_expect.pop_front();
                    checks++;
                    if (rx_beat.data !== want.data || rx_beat.keep !== want.keep ||
                        rx_beat.last !== want.last || rx_beat.id !== 8'(PORT_NUM)) begin
                        errors++;
                        $display("mismatch at %0t: rx beat %h/%h/%b/%0d, expected %h/%h/%b/%0d",
                                 $time, rx_beat.data, rx_beat.keep, rx_beat.last, rx_beat.id,
                                 want.data, want.keep, want.last, PORT_NUM);
                    end
                    // Receive counts follow the predicted beat
                    rx_bytes_m += 32'($countones(want.keep));
                    if (want.last) rx_pkts_m++;
                end
            end
            if (tx_beat.valid && tx_ready.ready) begin
                tx_bytes_m += 32'($countones(tx_beat.keep));
                if (tx_beat.last) tx_pkts_m++;
                if (loop_model) rx_expect.push_back(tx_beat);
            end
            // Drop mode never stalls and never returns beats
            if (!loop_model && rx_beat.valid) begin
                errors++;
                $display("Receive beat valid at %0t with loopback off", $time);
            end
            if (!loop_model && tx_beat.valid && !tx_ready.ready) begin
                errors++;
                $display("Transmit stalled at %0t with loopback off", $time);
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin : stimulus
        logic [31:0] data;
        logic [1:0]  resp;
        logic [31:0] rx_pkts_before;
        logic [31:0] rx_bytes_before;
        arst_n     = 1'b0;
        tx_beat    = '0;
        rx_ready   = '0;
        reg_req    = '0;
        tx_pkts_m  = '0;
        tx_bytes_m = '0;
        rx_pkts_m  = '0;
        rx_bytes_m = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        // Reset state
        check_counters();
        read_reg(REG_CTRL, data, resp);
        expect_equal("control after reset", data, 32'd0);

        // Identity and decode errors
        read_reg(REG_ID, data, resp);
        expect_equal("identity", data, 32'hCAC0_0005);
        expect_equal("identity response", 32'(resp), 32'd0);
        read_reg(8'h40, data, resp);
        expect_equal("unmapped read data", data, 32'd0);
        expect_equal("unmapped read response", 32'(resp), 32'd3);
        write_reg(8'h40, 32'hFFFF_FFFF, resp);
        expect_equal("unmapped write response", 32'(resp), 32'd3);

        // Loopback under back-pressure
        write_reg(REG_CTRL, 32'h1, resp);
        expect_equal("control write response", 32'(resp), 32'd0);
        loop_model = 1'b1;
        read_reg(REG_CTRL, data, resp);
        expect_equal("control with loopback", data, 32'd1);
        send_packets(40);
        drain_rx();
        check_counters();

        // Drop mode
        write_reg(REG_CTRL, 32'h0, resp);
        loop_model      = 1'b0;
        rx_pkts_before  = rx_pkts_m;
        rx_bytes_before = rx_bytes_m;
        send_packets(25);
        drain_rx();
        check_counters();
        read_reg(REG_RX_PKTS, data, resp);
        expect_equal("rx packets after drop mode", data, rx_pkts_before);
        read_reg(REG_RX_BYTES, data, resp);
        expect_equal("rx bytes after drop mode", data, rx_bytes_before);

        // Clear together with loopback on
        write_reg(REG_CTRL, 32'h3, resp);
        loop_model = 1'b1;
        tx_pkts_m  = '0;
        tx_bytes_m = '0;
        rx_pkts_m  = '0;
        rx_bytes_m = '0;
        check_counters();
        read_reg(REG_CTRL, data, resp);
        expect_equal("control after clear", data, 32'd1);
        send_packets(15);
        drain_rx();
        check_counters();

        // Clear with loopback off
        write_reg(REG_CTRL, 32'h2, resp);
        loop_model = 1'b0;
        tx_pkts_m  = '0;
        tx_bytes_m = '0;
        rx_pkts_m  = '0;
        rx_bytes_m = '0;
        check_counters();
        read_reg(REG_CTRL, data, resp);
        expect_equal("control after second clear", data, 32'd0);

        finish_run();
    end

endmodule : cmac_port_tb
